// File: compile.f
logic/spi_cfg_pkg.sv
logic/spi_bus_pkg.sv
logic/spi_sync_fifo.sv
logic/spi_apb_regs.sv
logic/spi_master_engine.sv
logic/spi_top.sv
verif/spi_slave_model.sv
verif/spi_tb.sv

// File: logic/spi_apb_regs.sv
// APB register block of the SPI master
// decodes accesses with slave-error checking, holds CTRL and BAUD,
// the sticky overflow flag, builds STATUS and returns registered read data
module spi_apb_regs #(
	parameter int FIFO_DEPTH = 8
) (
	input  logic                    pclk,
	input  logic                    preset_n,
	input  spi_bus_pkg::apb_req_t   apb_req,
	input  spi_bus_pkg::fifo_stat_t tx_stat,
	input  spi_bus_pkg::fifo_stat_t rx_stat,
	input  spi_cfg_pkg::frame_t     rx_head,
	input  logic                    busy,
	input  logic                    overflow,
	output spi_bus_pkg::apb_rsp_t   apb_rsp,
	output spi_cfg_pkg::spi_mode_t  mode,
	output spi_cfg_pkg::baud_t      baud,
	output logic                    soft_rst,
	output logic                    tx_push,
	output spi_cfg_pkg::frame_t     tx_data,
	output logic                    rx_pop
);
	import spi_cfg_pkg::*;
	import spi_bus_pkg::*;

	reg_idx_t  idx;
	logic      setup_ph;
	logic      access_ph;
	logic      err;
	logic      wr_ok;
	logic      rd_ok;
	word_t     rd_word;
	status_t   status;
	spi_mode_t mode_q;
	baud_t     baud_q;
	logic      srst_q;
	logic      ovf_q;
	word_t     prdata_q;
	logic      pslverr_q;

	// ========================================
	// decode
	// ========================================
	assign idx       = apb_req.paddr[ADDR_W-1:2];
	assign setup_ph  = apb_req.psel && !apb_req.penable;
	assign access_ph = apb_req.psel && apb_req.penable;

	// misaligned, unmapped, partial write, write to read-only
	always_comb
	begin
		err = 1'b0;
		if (apb_req.paddr[1:0] != 2'b00)
			err = 1'b1;
		if (idx > REG_RXDATA)
			err = 1'b1;
		if (apb_req.pwrite && !(&apb_req.pstrb))
			err = 1'b1;
		if (apb_req.pwrite && (idx == REG_STATUS || idx == REG_RXDATA))
			err = 1'b1;
	end

	assign wr_ok = access_ph && apb_req.pwrite && !err;
	assign rd_ok = access_ph && !apb_req.pwrite && !err;

	// full tx fifo silently drops the write
	assign tx_push = wr_ok && (idx == REG_TXDATA) && !tx_stat.full;
	assign tx_data = apb_req.pwdata[FRAME_W-1:0];
	assign rx_pop  = rd_ok && (idx == REG_RXDATA) && !rx_stat.empty;

	// ========================================
	// control, baud, overflow
	// ========================================
	always_ff @(posedge pclk or negedge preset_n)
	begin
		if (!preset_n)
		begin
			mode_q <= '0;
			baud_q <= '0;
			srst_q <= 1'b0;
		end
		else if (wr_ok && idx == REG_CTRL)
		begin
			mode_q.enable <= apb_req.pwdata[CTRL_EN];
			mode_q.cpol   <= apb_req.pwdata[CTRL_CPOL];
			mode_q.cpha   <= apb_req.pwdata[CTRL_CPHA];
			mode_q.ss_sel <= apb_req.pwdata[CTRL_SS +: $bits(ss_sel_t)];
			srst_q        <= apb_req.pwdata[CTRL_SRST];
		end
		else if (wr_ok && idx == REG_BAUD)
			baud_q <= apb_req.pwdata[BAUD_W-1:0];
	end

	// sticky until soft reset
	always_ff @(posedge pclk or negedge preset_n)
	begin
		if (!preset_n)
			ovf_q <= 1'b0;
		else if (srst_q)
			ovf_q <= 1'b0;
		else if (overflow)
			ovf_q <= 1'b1;
	end

	assign mode     = mode_q;
	assign baud     = baud_q;
	assign soft_rst = srst_q;

	// ========================================
	// status and read mux
	// ========================================
	always_comb
	begin
		status          = '0;
		status.tx_level = tx_stat.level;
		status.rx_level = rx_stat.level;
		status.tx_empty = tx_stat.empty;
		status.tx_full  = tx_stat.full;
		status.rx_empty = rx_stat.empty;
		status.rx_full  = rx_stat.full;
		status.busy     = busy;
		status.ovf      = ovf_q;
	end

	// TXDATA and empty RXDATA read back zero
	always_comb
	begin
		rd_word = '0;
		case (idx)
			REG_CTRL:
			begin
				rd_word[CTRL_EN]   = mode_q.enable;
				rd_word[CTRL_CPOL] = mode_q.cpol;
				rd_word[CTRL_CPHA] = mode_q.cpha;
				rd_word[CTRL_SRST] = srst_q;
				rd_word[CTRL_SS +: $bits(ss_sel_t)] = mode_q.ss_sel;
			end
			REG_BAUD:
				rd_word[BAUD_W-1:0] = baud_q;
			REG_STATUS:
				rd_word = status;
			REG_RXDATA:
			begin
				if (!rx_stat.empty)
					rd_word[FRAME_W-1:0] = rx_head;
			end
			default:
				rd_word = '0;
		endcase
	end

	// response captured at the setup edge, valid during access
	always_ff @(posedge pclk or negedge preset_n)
	begin
		if (!preset_n)
			pslverr_q <= 1'b0;
		else
			pslverr_q <= setup_ph && err;
	end

	always_ff @(posedge pclk)
	begin
		if (setup_ph && !apb_req.pwrite)
			prdata_q <= err ? '0 : rd_word;
	end

	assign apb_rsp.prdata  = prdata_q;
	assign apb_rsp.pready  = 1'b1;
	assign apb_rsp.pslverr = pslverr_q;

	// fifo side effects only in an access phase that followed its setup
	a_access_only: assert property (@(posedge pclk) disable iff (!preset_n)
		(tx_push || rx_pop) |-> apb_req.penable && $past(setup_ph))
		else $error("spi_apb_regs: fifo strobe outside access phase");

	// levels from both fifos stay within the configured depth
	a_level_range: assert property (@(posedge pclk) disable iff (!preset_n)
		(tx_stat.level <= FIFO_DEPTH) && (rx_stat.level <= FIFO_DEPTH))
		else $error("spi_apb_regs: fifo level above depth");

endmodule

// File: logic/spi_bus_pkg.sv
// SPI master bus-side package
// APB request/response structs, FIFO status and the STATUS register layout
package spi_bus_pkg;

	// widest level, covers depth 16
	localparam int LVL_W  = 5;
	localparam int STRB_W = 4;

	// ========================================
	// APB
	// ========================================
	typedef struct packed {
		logic                psel;
		logic                penable;
		logic                pwrite;
		spi_cfg_pkg::addr_t  paddr;
		spi_cfg_pkg::word_t  pwdata;
		logic [STRB_W-1:0]   pstrb;
	} apb_req_t;

	// pready tied high in the slave
	typedef struct packed {
		spi_cfg_pkg::word_t  prdata;
		logic                pready;
		logic                pslverr;
	} apb_rsp_t;

	// fifo level and flags
	typedef struct packed {
		logic [LVL_W-1:0] level;
		logic             full;
		logic             empty;
	} fifo_stat_t;

	// STATUS word as seen by software
	typedef struct packed {
		logic [9:0]       rsvd_hi;
		logic             ovf;
		logic             busy;
		logic             rx_full;
		logic             rx_empty;
		logic             tx_full;
		logic             tx_empty;
		logic [2:0]       rsvd_rx;
		logic [LVL_W-1:0] rx_level;
		logic [2:0]       rsvd_tx;
		logic [LVL_W-1:0] tx_level;
	} status_t;

endpackage

// File: logic/spi_cfg_pkg.sv
// SPI master configuration package
// frame and bus widths, register map and line-side types
package spi_cfg_pkg;

	// ========================================
	// widths
	// ========================================
	localparam int FRAME_W = 8;
	localparam int WORD_W  = 32;
	localparam int ADDR_W  = 5;
	localparam int BAUD_W  = 8;
	localparam int NUM_SS  = 4;

	typedef logic [FRAME_W-1:0]        frame_t;
	typedef logic [WORD_W-1:0]         word_t;
	typedef logic [ADDR_W-1:0]         addr_t;
	typedef logic [BAUD_W-1:0]         baud_t;
	typedef logic [$clog2(NUM_SS)-1:0] ss_sel_t;
	// one line per slave, low selects
	typedef logic [NUM_SS-1:0]         ss_n_t;

	// ========================================
	// register map, word index = paddr[4:2]
	// ========================================
	typedef logic [2:0] reg_idx_t;

	localparam reg_idx_t REG_CTRL   = 3'd0;
	localparam reg_idx_t REG_BAUD   = 3'd1;
	localparam reg_idx_t REG_STATUS = 3'd2;
	localparam reg_idx_t REG_TXDATA = 3'd3;
	localparam reg_idx_t REG_RXDATA = 3'd4;

	// ctrl bit positions
	localparam int CTRL_EN   = 0;
	localparam int CTRL_CPOL = 1;
	localparam int CTRL_CPHA = 2;
	localparam int CTRL_SRST = 3;
	// slave index occupies 5:4
	localparam int CTRL_SS   = 4;

	// line configuration handed to the engine
	typedef struct packed {
		logic    cpol;
		logic    cpha;
		ss_sel_t ss_sel;
		logic    enable;
	} spi_mode_t;

endpackage

// File: logic/spi_master_engine.sv
// SPI master frame engine
// pops a frame, drives sclk from the baud divider in any CPOL/CPHA mode,
// shifts mosi/miso MSB first and pushes the received frame
module spi_master_engine (
	input  logic                    pclk,
	input  logic                    preset_n,
	input  spi_cfg_pkg::spi_mode_t  mode,
	input  spi_cfg_pkg::baud_t      baud,
	input  logic                    abort,
	input  spi_bus_pkg::fifo_stat_t tx_stat,
	input  spi_cfg_pkg::frame_t     tx_head,
	input  logic                    rx_full,
	input  logic                    miso,
	output logic                    tx_pop,
	output logic                    rx_push,
	output spi_cfg_pkg::frame_t     rx_data,
	output logic                    busy,
	output logic                    overflow,
	output logic                    sclk,
	output logic                    mosi,
	output spi_cfg_pkg::ss_n_t      ss_n
);
	import spi_cfg_pkg::*;

	// two sclk edges per bit
	localparam int EDGES = 2 * FRAME_W;
	localparam int EW    = $clog2(EDGES);
	localparam logic [EW-1:0] LAST_EDGE = EW'(EDGES - 1);

	typedef enum logic [1:0] {
		IDLE,
		SHIFT,
		LEAD_OUT
	} state_t;

	state_t        state;
	baud_t         div_cnt;
	logic [EW-1:0] edge_cnt;
	frame_t        tx_sr;
	frame_t        rx_sr;
	logic          start;
	logic          tick;
	logic          lead;
	logic          sample_now;
	logic          drive_now;

	// ========================================
	// timing
	// ========================================
	assign start = (state == IDLE) && mode.enable && !abort && !tx_stat.empty;
	// end of a half-period, baud+1 pclk long
	assign tick  = (div_cnt == baud);
	// even edge count -> next edge leaves idle level
	assign lead  = !edge_cnt[0];
	// cpha 0 samples leading, cpha 1 samples trailing
	assign sample_now = (state == SHIFT) && tick && (lead != mode.cpha);
	assign drive_now  = (state == SHIFT) && tick && (lead == mode.cpha);

	always_ff @(posedge pclk or negedge preset_n)
	begin
		if (!preset_n)
		begin
			state    <= IDLE;
			div_cnt  <= '0;
			edge_cnt <= '0;
			sclk     <= 1'b0;
			mosi     <= 1'b0;
			ss_n     <= '1;
			rx_push  <= 1'b0;
			overflow <= 1'b0;
		end
		else
		begin
			rx_push  <= 1'b0;
			overflow <= 1'b0;
			if (abort)
			begin
				state <= IDLE;
				sclk  <= mode.cpol;
				mosi  <= 1'b0;
				ss_n  <= '1;
			end
			else
			begin
				case (state)
					IDLE:
					begin
						sclk <= mode.cpol;
						if (start)
						begin
							state    <= SHIFT;
							div_cnt  <= '0;
							edge_cnt <= '0;
							ss_n     <= ~(ss_n_t'(1) << mode.ss_sel);
							// cpha 0 puts the msb out before the first edge
							mosi     <= mode.cpha ? 1'b0 : tx_head[FRAME_W-1];
						end
					end
					SHIFT:
					begin
						if (tick)
						begin
							div_cnt  <= '0;
							sclk     <= !sclk;
							edge_cnt <= edge_cnt + 1'b1;
							if (edge_cnt == LAST_EDGE)
								state <= LEAD_OUT;
						end
						else
							div_cnt <= div_cnt + 1'b1;
						if (drive_now)
							mosi <= tx_sr[FRAME_W-1];
					end
					LEAD_OUT:
					begin
						// one half-period hold, then deselect and hand over
						if (tick)
						begin
							state    <= IDLE;
							div_cnt  <= '0;
							ss_n     <= '1;
							mosi     <= 1'b0;
							rx_push  <= !rx_full;
							overflow <= rx_full;
						end
						else
							div_cnt <= div_cnt + 1'b1;
					end
					default:
						state <= IDLE;
				endcase
			end
		end
	end

	// ========================================
	// shift registers
	// ========================================
	always_ff @(posedge pclk)
	begin
		if (start)
			tx_sr <= mode.cpha ? tx_head : (tx_head << 1);
		else if (drive_now)
			tx_sr <= tx_sr << 1;
		if (sample_now)
			rx_sr <= {rx_sr[FRAME_W-2:0], miso};
	end

	assign tx_pop  = start;
	assign rx_data = rx_sr;
	assign busy    = (state != IDLE);

	// never more than one slave selected
	a_one_select: assert property (@(posedge pclk) disable iff (!preset_n)
		$onehot0(~ss_n))
		else $error("spi_master_engine: several ss_n low");

	a_pop_nonempty: assert property (@(posedge pclk) disable iff (!preset_n)
		tx_pop |-> !tx_stat.empty)
		else $error("spi_master_engine: pop from empty tx fifo");

endmodule

// File: logic/spi_sync_fifo.sv
// synchronous frame FIFO for the SPI master
// register array with first-word fall-through head,
// level, full and empty derived from wrapping pointers
module spi_sync_fifo #(
	parameter int FIFO_DEPTH = 8
) (
	input  logic                    pclk,
	input  logic                    preset_n,
	input  logic                    clear,
	input  logic                    push,
	input  spi_cfg_pkg::frame_t     push_data,
	input  logic                    pop,
	output spi_cfg_pkg::frame_t     pop_data,
	output spi_bus_pkg::fifo_stat_t stat
);
	import spi_cfg_pkg::*;
	import spi_bus_pkg::*;

	localparam int AW = $clog2(FIFO_DEPTH);

	// ========================================
	// pointers and storage
	// ========================================
	// extra msb on each pointer tells full from empty
	logic [AW:0] wr_ptr;
	logic [AW:0] rd_ptr;
	logic [AW:0] count;
	logic        wr_en;
	logic        rd_en;
	frame_t      mem [FIFO_DEPTH];

	// push on full / pop on empty dropped here
	assign wr_en = push && !stat.full;
	assign rd_en = pop && !stat.empty;

	always_ff @(posedge pclk or negedge preset_n)
	begin
		if (!preset_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else if (clear)
		begin
			// clear beats push and pop
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else
		begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_en)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge pclk)
	begin
		if (wr_en)
			mem[wr_ptr[AW-1:0]] <= push_data;
	end

	// head visible without a read cycle
	assign pop_data = mem[rd_ptr[AW-1:0]];

	// ========================================
	// status
	// ========================================
	assign count      = wr_ptr - rd_ptr;
	assign stat.level = LVL_W'(count);
	assign stat.full  = (count == (AW+1)'(FIFO_DEPTH));
	assign stat.empty = (count == '0);

	// producers check full before pushing
	a_no_push_full: assert property (@(posedge pclk) disable iff (!preset_n)
		push |-> !stat.full)
		else $error("spi_sync_fifo: push while full");

endmodule

// File: logic/spi_top.sv
// SPI master top level
// APB register block, transmit and receive FIFOs and the master engine
module spi_top #(
	parameter int FIFO_DEPTH = 8
) (
	input  logic                  pclk,
	input  logic                  preset_n,
	input  spi_bus_pkg::apb_req_t apb_req,
	input  logic                  miso,
	output spi_bus_pkg::apb_rsp_t apb_rsp,
	output logic                  sclk,
	output logic                  mosi,
	output spi_cfg_pkg::ss_n_t    ss_n
);
	import spi_cfg_pkg::*;
	import spi_bus_pkg::*;

	// fifo side
	fifo_stat_t tx_stat;
	fifo_stat_t rx_stat;
	frame_t     tx_head;
	frame_t     rx_head;
	frame_t     tx_data;
	frame_t     rx_data;
	logic       tx_push;
	logic       tx_pop;
	logic       rx_push;
	logic       rx_pop;
	// configuration and engine status
	spi_mode_t  mode;
	baud_t      baud;
	logic       soft_rst;
	logic       busy;
	logic       overflow;

	// ========================================
	// bus side
	// ========================================
	spi_apb_regs #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) regs_i (
		.pclk(pclk),
		.preset_n(preset_n),
		.apb_req(apb_req),
		.tx_stat(tx_stat),
		.rx_stat(rx_stat),
		.rx_head(rx_head),
		.busy(busy),
		.overflow(overflow),
		.apb_rsp(apb_rsp),
		.mode(mode),
		.baud(baud),
		.soft_rst(soft_rst),
		.tx_push(tx_push),
		.tx_data(tx_data),
		.rx_pop(rx_pop)
	);

	// software to line
	spi_sync_fifo #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) tx_fifo (
		.pclk(pclk),
		.preset_n(preset_n),
		.clear(soft_rst),
		.push(tx_push),
		.push_data(tx_data),
		.pop(tx_pop),
		.pop_data(tx_head),
		.stat(tx_stat)
	);

	// line to software
	spi_sync_fifo #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) rx_fifo (
		.pclk(pclk),
		.preset_n(preset_n),
		.clear(soft_rst),
		.push(rx_push),
		.push_data(rx_data),
		.pop(rx_pop),
		.pop_data(rx_head),
		.stat(rx_stat)
	);

	// ========================================
	// line side
	// ========================================
	spi_master_engine engine_i (
		.pclk(pclk),
		.preset_n(preset_n),
		.mode(mode),
		.baud(baud),
		.abort(soft_rst),
		.tx_stat(tx_stat),
		.tx_head(tx_head),
		.rx_full(rx_stat.full),
		.miso(miso),
		.tx_pop(tx_pop),
		.rx_push(rx_push),
		.rx_data(rx_data),
		.busy(busy),
		.overflow(overflow),
		.sclk(sclk),
		.mosi(mosi),
		.ss_n(ss_n)
	);

endmodule

// File: run.sh
#!/bin/sh
# build and run the SPI master testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal -f compile.f --top-module spi_tb -Mdir obj_dir

./obj_dir/Vspi_tb > sim.log 2>&1
cat sim.log

# the verdict comes from the log
grep -q '^>>> PASS$' sim.log

// File: verif/spi_slave_model.sv
// behavioural SPI slave for the master testbench
// samples mosi and drives miso per CPOL/CPHA, one random reply byte per frame,
// logs both directions of every complete frame
module spi_slave_model (
	input  logic               sclk,
	input  logic               mosi,
	input  spi_cfg_pkg::ss_n_t ss_n,
	input  logic               cpol,
	input  logic               cpha,
	output logic               miso
);
	timeunit 1ns;
	timeprecision 100ps;
	import spi_cfg_pkg::*;

	// one entry per complete frame with the oldest first
	frame_t mosi_log[$];
	frame_t miso_log[$];

	frame_t tx_byte;
	frame_t rx_byte;
	int     drv_cnt;
	int     smp_cnt;
	logic   sel_now;
	logic   sel_q  = 1'b0;
	logic   sclk_q = 1'b0;

	// line quiet until the first select
	initial
		miso = 1'b0;

	// one process sees select and clock edges in order
	always @(ss_n or sclk)
	begin
		sel_now = (ss_n != '1);
		if (!sel_now)
		begin
			// frames cut short are not logged
			if (sel_q && smp_cnt == FRAME_W)
			begin
				mosi_log.push_back(rx_byte);
				miso_log.push_back(tx_byte);
			end
			miso = 1'b0;
		end
		else if (!sel_q)
		begin
			tx_byte = frame_t'($urandom);
			rx_byte = '0;
			smp_cnt = 0;
			// cpha 0 needs the msb on the line before the first edge
			if (!cpha)
			begin
				miso    = tx_byte[FRAME_W-1];
				drv_cnt = 1;
			end
			else
			begin
				miso    = 1'b0;
				drv_cnt = 0;
			end
		end
		else if (sclk != sclk_q)
		begin
			// leading edge leaves the idle level
			if ((sclk != cpol) != cpha)
			begin
				if (smp_cnt < FRAME_W)
				begin
					rx_byte = {rx_byte[FRAME_W-2:0], mosi};
					smp_cnt++;
				end
			end
			else if (drv_cnt < FRAME_W)
			begin
				miso = tx_byte[FRAME_W-1-drv_cnt];
				drv_cnt++;
			end
		end
		sel_q  = sel_now;
		sclk_q = sclk;
	end

endmodule

// File: verif/spi_tb.sv
// testbench for the APB SPI master
// APB read/write tasks, random frames in all four modes, slave-error checks,
// FIFO saturation, overflow and soft reset, checked against queue models
module spi_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import spi_cfg_pkg::*;
	import spi_bus_pkg::*;

	localparam int          DEPTH    = 8;
	localparam int          N_FRAMES = 6;
	// pclk cycles allowed per frame wait
	localparam int          WAIT_TMO = 5000;
	localparam int          QUIET    = 300;
	localparam logic [31:0] SEED     = 32'h15c50791;

	logic     pclk;
	logic     preset_n;
	apb_req_t apb_req;
	apb_rsp_t apb_rsp;
	logic     miso;
	logic     sclk;
	logic     mosi;
	ss_n_t    ss_n;
	logic     cur_cpol;
	logic     cur_cpha;

	// line monitor cleared while disabled
	logic     mon_en;
	ss_n_t    ss_low   = '0;
	int       idle_bad = 0;

	int       errors;
	int       tests_run;
	int       tests_bad;
	frame_t   sent_q[$];
	frame_t   rx_q[$];

	spi_top #(
		.FIFO_DEPTH(DEPTH)
	) spi_top_i (
		.pclk(pclk),
		.preset_n(preset_n),
		.apb_req(apb_req),
		.miso(miso),
		.apb_rsp(apb_rsp),
		.sclk(sclk),
		.mosi(mosi),
		.ss_n(ss_n)
	);

	spi_slave_model slave_i (
		.sclk(sclk),
		.mosi(mosi),
		.ss_n(ss_n),
		.cpol(cur_cpol),
		.cpha(cur_cpha),
		.miso(miso)
	);

	always #5 pclk = ~pclk;

	always @(negedge pclk)
	begin
		if (!mon_en)
		begin
			ss_low   = '0;
			idle_bad = 0;
		end
		else
		begin
			ss_low = ss_low | ~ss_n;
			// deselected line must rest at cpol
			if (ss_n == '1 && sclk !== cur_cpol)
				idle_bad++;
		end
	end

	// ========================================
	// reporting
	// ========================================
	task automatic report_mismatch(input string name, input word_t exp, input word_t act);
		errors++;
		$display("error at %0t: %s expected 0x%0h actual 0x%0h", $time, name, exp, act);
	endtask

	task automatic report_failure(input string msg);
		errors++;
		$display("%0t: %s", $time, msg);
	endtask

	task automatic end_test(input string name, input int err_start);
		tests_run++;
		if (errors == err_start)
			$display("test %s: ok", name);
		else
		begin
			tests_bad++;
			$display("test %s: %0d errors", name, errors - err_start);
		end
	endtask

	// ========================================
	// register helpers and APB
	// ========================================
	function automatic addr_t reg_addr(input reg_idx_t idx);
		return {idx, 2'b00};
	endfunction

	// en bit 0, cpol 1, cpha 2, soft reset 3, slave 5:4
	function automatic word_t ctrl_word(input logic en, input logic cpol, input logic cpha,
			input logic srst, input ss_sel_t ss);
		word_t w;
		w      = '0;
		w[0]   = en;
		w[1]   = cpol;
		w[2]   = cpha;
		w[3]   = srst;
		w[5:4] = ss;
		return w;
	endfunction

	// flag order from msb is ovf busy rx_full rx_empty tx_full tx_empty
	function automatic word_t status_word(input int tx_lvl, input int rx_lvl,
			input logic [5:0] flags);
		word_t w;
		w        = '0;
		w[4:0]   = 5'(tx_lvl);
		w[12:8]  = 5'(rx_lvl);
		w[21:16] = flags;
		return w;
	endfunction

	// setup then access with no wait states
	task automatic apb_xfer(input logic wr, input addr_t addr, input word_t wdata,
			input logic [3:0] strb, output word_t rdata, output logic slverr);
		@(posedge pclk);
		apb_req.psel    <= 1'b1;
		apb_req.penable <= 1'b0;
		apb_req.pwrite  <= wr;
		apb_req.paddr   <= addr;
		apb_req.pwdata  <= wdata;
		apb_req.pstrb   <= strb;
		@(posedge pclk);
		apb_req.penable <= 1'b1;
		// response registered at the setup edge
		@(negedge pclk);
		rdata  = apb_rsp.prdata;
		slverr = apb_rsp.pslverr;
		if (apb_rsp.pready !== 1'b1)
			report_failure("pready was low in the access phase");
		@(posedge pclk);
		apb_req.psel    <= 1'b0;
		apb_req.penable <= 1'b0;
	endtask

	task automatic reg_write(input addr_t addr, input word_t data);
		word_t rd;
		logic  err;
		apb_xfer(1'b1, addr, data, 4'hf, rd, err);
		if (err)
			report_failure($sformatf("slave error on a valid write to 0x%0h", addr));
	endtask

	task automatic reg_read(input addr_t addr, output word_t data);
		logic err;
		apb_xfer(1'b0, addr, '0, 4'h0, data, err);
		if (err)
			report_failure($sformatf("slave error on a valid read of 0x%0h", addr));
	endtask

	task automatic bad_access(input logic wr, input addr_t addr, input logic [3:0] strb);
		word_t rd;
		logic  err;
		apb_xfer(wr, addr, '1, strb, rd, err);
		if (!err)
			report_failure($sformatf("no slave error for bad access to 0x%0h", addr));
		if (!wr && rd !== '0)
			report_mismatch("prdata on bad read", '0, rd);
	endtask

	task automatic check_status(input word_t exp);
		word_t rd;
		reg_read(reg_addr(REG_STATUS), rd);
		if (rd !== exp)
			report_mismatch("STATUS", exp, rd);
	endtask

	// ========================================
	// frame traffic
	// ========================================
	task automatic send_byte(input frame_t b);
		reg_write(reg_addr(REG_TXDATA), word_t'(b));
		sent_q.push_back(b);
	endtask

	task automatic wait_frames(input int target);
		int cycles;
		cycles = 0;
		while (slave_i.mosi_log.size() < target && cycles < WAIT_TMO)
		begin
			@(negedge pclk);
			cycles++;
		end
		if (slave_i.mosi_log.size() < target)
			report_failure($sformatf("timed out waiting for frame %0d at the slave", target));
	endtask

	// sent bytes against the slave log, then RXDATA against the slave replies
	task automatic check_frames(input int base, input int n_sent, input int n_read);
		word_t  rd;
		frame_t exp;
		for (int i = 0; i < n_sent; i++)
		begin
			exp = sent_q.pop_front();
			if (slave_i.mosi_log[base+i] !== exp)
				report_mismatch("mosi frame", word_t'(exp), word_t'(slave_i.mosi_log[base+i]));
		end
		for (int i = 0; i < n_read; i++)
			rx_q.push_back(slave_i.miso_log[base+i]);
		for (int i = 0; i < n_read; i++)
		begin
			reg_read(reg_addr(REG_RXDATA), rd);
			exp = rx_q.pop_front();
			if (rd !== word_t'(exp))
				report_mismatch("RXDATA", word_t'(exp), rd);
		end
		sent_q.delete();
	endtask

	// ========================================
	// test sequence
	// ========================================
	initial
	begin
		int      err_start;
		int      base;
		word_t   rd;
		baud_t   baud_val;
		ss_sel_t ss_val;

		void'($urandom(SEED));
		pclk      = 1'b0;
		preset_n  = 1'b0;
		apb_req   = '0;
		cur_cpol  = 1'b0;
		cur_cpha  = 1'b0;
		mon_en    = 1'b0;
		errors    = 0;
		tests_run = 0;
		tests_bad = 0;
		repeat (4) @(posedge pclk);
		preset_n <= 1'b1;

		// idle state after reset
		err_start = errors;
		check_status(status_word(0, 0, 6'b000101));
		@(negedge pclk);
		if (ss_n !== 4'hf)
			report_mismatch("ss_n", 32'hf, word_t'(ss_n));
		if (sclk !== 1'b0)
			report_mismatch("sclk", 0, word_t'(sclk));
		end_test("reset state", err_start);

		// all four modes with random baud and slave
		for (int m = 0; m < 4; m++)
		begin
			err_start = errors;
			cur_cpol  = m[1];
			cur_cpha  = m[0];
			baud_val  = baud_t'($urandom_range(0, 3));
			ss_val    = ss_sel_t'($urandom_range(0, 3));
			reg_write(reg_addr(REG_BAUD), word_t'(baud_val));
			reg_write(reg_addr(REG_CTRL), ctrl_word(1'b1, cur_cpol, cur_cpha, 1'b0, ss_val));
			// sclk settles to the new cpol one cycle later
			@(posedge pclk);
			mon_en = 1'b1;
			base   = slave_i.mosi_log.size();
			for (int i = 0; i < N_FRAMES; i++)
				send_byte(frame_t'($urandom));
			wait_frames(base + N_FRAMES);
			check_frames(base, N_FRAMES, N_FRAMES);
			if (ss_low !== ss_n_t'(1 << ss_val))
				report_mismatch("ss_n lines driven low", word_t'(1 << ss_val), word_t'(ss_low));
			if (idle_bad != 0)
				report_failure("sclk left cpol while no slave was selected");
			mon_en = 1'b0;
			end_test($sformatf("mode %0d", m), err_start);
		end

		// slave errors leave registers untouched
		err_start = errors;
		cur_cpol  = 1'b1;
		reg_write(reg_addr(REG_CTRL), 32'h22);
		reg_write(reg_addr(REG_BAUD), 32'h5a);
		bad_access(1'b1, 5'h01, 4'hf);
		bad_access(1'b0, 5'h01, 4'h0);
		bad_access(1'b0, 5'h06, 4'h0);
		bad_access(1'b0, 5'h14, 4'h0);
		bad_access(1'b0, 5'h18, 4'h0);
		bad_access(1'b0, 5'h1c, 4'h0);
		bad_access(1'b1, 5'h15, 4'hf);
		bad_access(1'b1, reg_addr(REG_CTRL), 4'b0111);
		bad_access(1'b1, reg_addr(REG_BAUD), 4'b1110);
		bad_access(1'b1, reg_addr(REG_STATUS), 4'hf);
		bad_access(1'b1, reg_addr(REG_RXDATA), 4'hf);
		reg_read(reg_addr(REG_CTRL), rd);
		if (rd !== 32'h22)
			report_mismatch("CTRL", 32'h22, rd);
		reg_read(reg_addr(REG_BAUD), rd);
		if (rd !== 32'h5a)
			report_mismatch("BAUD", 32'h5a, rd);
		end_test("slave errors", err_start);

		// tx fifo saturates while disabled
		err_start = errors;
		cur_cpol  = 1'b0;
		cur_cpha  = 1'b0;
		reg_write(reg_addr(REG_CTRL), ctrl_word(1'b0, 1'b0, 1'b0, 1'b0, 2'd0));
		reg_write(reg_addr(REG_BAUD), 32'h0);
		for (int i = 0; i < DEPTH; i++)
			send_byte(frame_t'($urandom));
		// these two are dropped by the full fifo
		reg_write(reg_addr(REG_TXDATA), 32'ha5);
		reg_write(reg_addr(REG_TXDATA), 32'h5a);
		check_status(status_word(DEPTH, 0, 6'b000110));
		base = slave_i.mosi_log.size();
		reg_write(reg_addr(REG_CTRL), ctrl_word(1'b1, 1'b0, 1'b0, 1'b0, 2'd0));
		// first frame is under way by the next setup edge
		reg_read(reg_addr(REG_STATUS), rd);
		if (rd[20] !== 1'b1)
			report_mismatch("STATUS busy", 1, word_t'(rd[20]));
		wait_frames(base + DEPTH);
		for (int i = 0; i < QUIET; i++)
			@(negedge pclk);
		if (slave_i.mosi_log.size() != base + DEPTH)
			report_mismatch("frames at slave", DEPTH, slave_i.mosi_log.size() - base);
		check_frames(base, DEPTH, DEPTH);
		end_test("tx fifo full", err_start);

		// rx overflow, then soft reset
		err_start = errors;
		base      = slave_i.mosi_log.size();
		for (int i = 0; i < DEPTH + 1; i++)
			send_byte(frame_t'($urandom));
		wait_frames(base + DEPTH + 1);
		check_status(status_word(0, DEPTH, 6'b101001));
		check_frames(base, DEPTH + 1, DEPTH);
		base = slave_i.mosi_log.size();
		reg_write(reg_addr(REG_TXDATA), word_t'(frame_t'($urandom)));
		reg_write(reg_addr(REG_TXDATA), word_t'(frame_t'($urandom)));
		wait_frames(base + 2);
		reg_write(reg_addr(REG_CTRL), ctrl_word(1'b0, 1'b0, 1'b0, 1'b0, 2'd0));
		reg_write(reg_addr(REG_TXDATA), word_t'(frame_t'($urandom)));
		reg_write(reg_addr(REG_TXDATA), word_t'(frame_t'($urandom)));
		check_status(status_word(2, 2, 6'b100000));
		reg_write(reg_addr(REG_CTRL), ctrl_word(1'b0, 1'b0, 1'b0, 1'b1, 2'd0));
		reg_write(reg_addr(REG_CTRL), ctrl_word(1'b0, 1'b0, 1'b0, 1'b0, 2'd0));
		check_status(status_word(0, 0, 6'b000101));
		end_test("rx overflow and soft reset", err_start);

		$display("tests run %0d, tests with errors %0d, errors %0d",
			tests_run, tests_bad, errors);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule
